//--- Makefile
# Verilator build and run of the RV32I pipeline testbench

TOP := rvCoreTb

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f rvCore.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

//--- rvCore.f
+incdir+source
source/rvIsaPkg.sv
source/rvPipePkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/hazardUnit.sv
source/rvCore.sv
tests/rvCore_assert.sv
tests/rvCoreTb.sv

//--- source/decodeStage.sv
`default_nettype none
`timescale 1ns/10ps

`include "rv_config.svh"

module decodeStage (
    input  logic               CLK,
    input  logic               rst,
    input  logic               flushE,
    input  logic               stall,
    input  rvPipePkg::ifId_t   ifId,
    input  rvPipePkg::wbPort_t wb,
    output rvPipePkg::idEx_t   idEx
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    opcode_t opcode;
    funct3_t funct3;
    regIdx_t rs1;
    regIdx_t rs2;
    regIdx_t rd;
    logic    altOp;
    ctrl_t   ctrl;
    word_t   imm;
    word_t   rs1Val;
    word_t   rs2Val;
    word_t   regs [`RV_REG_COUNT];

    assign opcode = ifId.instr[6:0];
    assign rd     = ifId.instr[11:7];
    assign funct3 = ifId.instr[14:12];
    assign rs1    = ifId.instr[19:15];
    assign rs2    = ifId.instr[24:20];

    // Bit 30 selects SUB and SRA; ADDI has no alternate form
    assign altOp = ifId.instr[30] && (opcode == OP_REG || funct3 == F3_SR);

    // ========================================
    // Control decode
    // ========================================
    always_comb begin
        ctrl = '0;
        case (opcode)
            OP_REG, OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.srcBImm  = (opcode == OP_IMM);
                case (funct3)
                    F3_ADD:  ctrl.aluOp = altOp ? ALU_SUB : ALU_ADD;
                    F3_SLL:  ctrl.aluOp = ALU_SLL;
                    F3_SLT:  ctrl.aluOp = ALU_SLT;
                    F3_XOR:  ctrl.aluOp = ALU_XOR;
                    F3_SR:   ctrl.aluOp = altOp ? ALU_SRA : ALU_SRL;
                    F3_OR:   ctrl.aluOp = ALU_OR;
                    F3_AND:  ctrl.aluOp = ALU_AND;
                    default: ctrl.regWrite = 1'b0;   // SLTU/SLTIU not supported
                endcase
            end
            OP_LUI: begin
                ctrl.regWrite = 1'b1;
                ctrl.srcAZero = 1'b1;
                ctrl.srcBImm  = 1'b1;
                ctrl.aluOp    = ALU_ADD;
            end
            OP_LOAD: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.srcBImm  = 1'b1;
                ctrl.aluOp    = ALU_ADD;
            end
            OP_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.srcBImm  = 1'b1;
                ctrl.aluOp    = ALU_ADD;
            end
            OP_BRANCH: begin
                // Unsigned compares fall through as not taken
                ctrl.isBranch = (funct3 == F3_BEQ) || (funct3 == F3_BNE) ||
                                (funct3 == F3_BLT) || (funct3 == F3_BGE);
            end
            default: ;   // Unknown opcode behaves as a no-op
        endcase
    end

    // Immediate by format
    always_comb begin
        case (opcode)
            OP_STORE:  imm = {{20{ifId.instr[31]}}, ifId.instr[31:25], ifId.instr[11:7]};
            OP_BRANCH: imm = {{19{ifId.instr[31]}}, ifId.instr[31], ifId.instr[7],
                              ifId.instr[30:25], ifId.instr[11:8], 1'b0};
            OP_LUI:    imm = {ifId.instr[31:12], 12'b0};
            default:   imm = {{20{ifId.instr[31]}}, ifId.instr[31:20]};
        endcase
    end

    // ========================================
    // Register file
    // ========================================
    always_ff @(posedge CLK) begin
        if (wb.regWrite && wb.rd != '0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // x0 reads zero, a same-cycle writeback wins over the array
    function automatic word_t readPort(regIdx_t idx, word_t stored, wbPort_t w);
        if (idx == '0) begin
            return '0;
        end
        if (w.regWrite && w.rd == idx) begin
            return w.result;
        end
        return stored;
    endfunction

    assign rs1Val = readPort(rs1, regs[rs1], wb);
    assign rs2Val = readPort(rs2, regs[rs2], wb);

    // Decode/execute register
    always_ff @(posedge CLK) begin
        if (rst || flushE) begin
            idEx.ctrl <= '0;   // Bubble
        end else if (!stall) begin
            idEx.ctrl <= ctrl;
        end
        if (!stall) begin
            idEx.pc     <= ifId.pc;
            idEx.rs1Val <= rs1Val;
            idEx.rs2Val <= rs2Val;
            idEx.imm    <= imm;
            idEx.rs1    <= rs1;
            idEx.rs2    <= rs2;
            idEx.rd     <= rd;
            idEx.funct3 <= funct3;
        end
    end

endmodule

`default_nettype wire

//--- source/executeStage.sv
`default_nettype none
`timescale 1ns/10ps

module executeStage (
    input  logic                 CLK,
    input  logic                 rst,
    input  rvPipePkg::idEx_t     idEx,
    input  rvPipePkg::fwdSel_t   fwd,
    input  rvPipePkg::wbPort_t   wb,
    output rvPipePkg::exMem_t    exMem,
    output rvPipePkg::redirect_t redirect
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    word_t opA;
    word_t opB;
    word_t srcA;
    word_t srcB;
    word_t aluResult;
    logic  branchCond;

    function automatic word_t fwdMux(fwdSrc_t sel, word_t regVal, word_t memVal,
                                     word_t wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    // Operands after forwarding
    assign opA = fwdMux(fwd.fwdA, idEx.rs1Val, exMem.aluResult, wb.result);
    assign opB = fwdMux(fwd.fwdB, idEx.rs2Val, exMem.aluResult, wb.result);

    assign srcA = idEx.ctrl.srcAZero ? '0 : opA;
    assign srcB = idEx.ctrl.srcBImm ? idEx.imm : opB;

    // ========================================
    // ALU
    // ========================================
    always_comb begin
        case (idEx.ctrl.aluOp)
            ALU_SUB: aluResult = srcA - srcB;
            ALU_AND: aluResult = srcA & srcB;
            ALU_OR:  aluResult = srcA | srcB;
            ALU_XOR: aluResult = srcA ^ srcB;
            ALU_SLT: aluResult = word_t'($signed(srcA) < $signed(srcB));
            ALU_SLL: aluResult = srcA << srcB[4:0];
            ALU_SRL: aluResult = srcA >> srcB[4:0];
            ALU_SRA: aluResult = word_t'($signed(srcA) >>> srcB[4:0]);
            default: aluResult = srcA + srcB;   // ADD, loads, stores, LUI
        endcase
    end

    // Branch resolution
    always_comb begin
        case (idEx.funct3)
            F3_BEQ:  branchCond = (opA == opB);
            F3_BNE:  branchCond = (opA != opB);
            F3_BLT:  branchCond = ($signed(opA) < $signed(opB));
            F3_BGE:  branchCond = ($signed(opA) >= $signed(opB));
            default: branchCond = 1'b0;
        endcase
    end

    assign redirect = '{taken:  idEx.ctrl.isBranch && branchCond,
                        target: idEx.pc + idEx.imm};

    // Execute/memory register
    always_ff @(posedge CLK) begin
        if (rst) begin
            exMem.regWrite <= 1'b0;
            exMem.memToReg <= 1'b0;
            exMem.memWrite <= 1'b0;
        end else begin
            exMem.regWrite <= idEx.ctrl.regWrite;
            exMem.memToReg <= idEx.ctrl.memToReg;
            exMem.memWrite <= idEx.ctrl.memWrite;
        end
        exMem.aluResult <= aluResult;
        exMem.storeData <= opB;   // Forwarded rs2
        exMem.rd        <= idEx.rd;
    end

endmodule

`default_nettype wire

//--- source/fetchStage.sv
`default_nettype none
`timescale 1ns/10ps

`include "rv_config.svh"

module fetchStage (
    input  logic                 CLK,
    input  logic                 rst,
    input  logic                 stall,
    input  logic                 flushD,
    input  rvPipePkg::redirect_t redirect,
    input  rvIsaPkg::instr_t     instr,
    output rvIsaPkg::addr_t      pc,
    output rvPipePkg::ifId_t     ifId
);
    import rvIsaPkg::*;

    addr_t pcNext;

    // Predict not taken, execute corrects it
    assign pcNext = redirect.taken ? redirect.target : pc + addr_t'(4);

    always_ff @(posedge CLK) begin
        if (rst) begin
            pc <= `RV_PC_INIT;
        end else if (!stall) begin
            pc <= pcNext;
        end
    end

    // ========================================
    // Fetch/decode register
    // ========================================
    always_ff @(posedge CLK) begin
        if (rst || flushD) begin
            ifId.instr <= NOP_INSTR;   // Squashed slot decodes as a no-op
        end else if (!stall) begin
            ifId.instr <= instr;
        end
        if (!stall) begin
            ifId.pc <= pc;
        end
    end

endmodule

`default_nettype wire

//--- source/hazardUnit.sv
`default_nettype none
`timescale 1ns/10ps

module hazardUnit (
    input  rvPipePkg::ifId_t   ifId,
    input  rvPipePkg::idEx_t   idEx,
    input  rvPipePkg::exMem_t  exMem,
    input  rvPipePkg::wbPort_t wb,
    input  logic               redirectTaken,
    output logic               stall,
    output logic               flushD,
    output logic               flushE,
    output rvPipePkg::fwdSel_t fwd
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    regIdx_t rs1D;
    regIdx_t rs2D;

    // Source fields of the instruction in decode
    assign rs1D = ifId.instr[19:15];
    assign rs2D = ifId.instr[24:20];

    // Youngest producer wins, x0 is never forwarded
    function automatic fwdSrc_t pickSource(regIdx_t rs, exMem_t m, wbPort_t w);
        if (rs == '0) begin
            return FWD_NONE;
        end
        if (m.regWrite && m.rd == rs) begin
            return FWD_MEM;
        end
        if (w.regWrite && w.rd == rs) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign fwd = '{fwdA: pickSource(idEx.rs1, exMem, wb),
                   fwdB: pickSource(idEx.rs2, exMem, wb)};

    // Load in execute feeding decode, one bubble
    assign stall = idEx.ctrl.memToReg && idEx.rd != '0 &&
                   (idEx.rd == rs1D || idEx.rd == rs2D);

    assign flushD = redirectTaken;
    assign flushE = redirectTaken || stall;

endmodule

`default_nettype wire

//--- source/memoryStage.sv
`default_nettype none
`timescale 1ns/10ps

module memoryStage (
    input  logic               CLK,
    input  logic               rst,
    input  rvPipePkg::exMem_t  exMem,
    input  rvIsaPkg::word_t    readData,
    output rvIsaPkg::addr_t    memAddr,
    output rvIsaPkg::word_t    writeData,
    output logic               memWrite,
    output logic               memRead,
    output rvPipePkg::wbPort_t wb
);
    import rvPipePkg::*;

    memWb_t memWb;

    // Data port, word accesses only
    assign memAddr   = exMem.aluResult;
    assign writeData = exMem.storeData;
    assign memWrite  = exMem.memWrite;
    assign memRead   = exMem.memToReg;

    // ========================================
    // Memory/writeback register
    // ========================================
    always_ff @(posedge CLK) begin
        if (rst) begin
            memWb.regWrite <= 1'b0;
            memWb.memToReg <= 1'b0;
        end else begin
            memWb.regWrite <= exMem.regWrite;
            memWb.memToReg <= exMem.memToReg;
        end
        memWb.aluResult <= exMem.aluResult;
        memWb.loadData  <= readData;
        memWb.rd        <= exMem.rd;
    end

    assign wb = '{regWrite: memWb.regWrite,
                  rd:       memWb.rd,
                  result:   memWb.memToReg ? memWb.loadData : memWb.aluResult};

endmodule

`default_nettype wire

//--- source/rvCore.sv
`default_nettype none
`timescale 1ns/10ps

module rvCore (
    input  logic             CLK,
    input  logic             rst,
    input  rvIsaPkg::instr_t instr,
    input  rvIsaPkg::word_t  readData,
    output rvIsaPkg::addr_t  pc,
    output rvIsaPkg::addr_t  memAddr,
    output rvIsaPkg::word_t  writeData,
    output logic             memWrite,
    output logic             memRead
);
    import rvPipePkg::*;

    ifId_t     ifId;
    idEx_t     idEx;
    exMem_t    exMem;
    wbPort_t   wb;
    redirect_t redirect;
    fwdSel_t   fwd;
    logic      stall;
    logic      flushD;
    logic      flushE;

    // ========================================
    // Pipeline stages
    // ========================================
    fetchStage fetch (
        .CLK     (CLK),
        .rst     (rst),
        .stall   (stall),
        .flushD  (flushD),
        .redirect(redirect),
        .instr   (instr),
        .pc      (pc),
        .ifId    (ifId)
    );

    decodeStage decode (
        .CLK   (CLK),
        .rst   (rst),
        .flushE(flushE),
        .stall (stall),
        .ifId  (ifId),
        .wb    (wb),       // Register write and bypass
        .idEx  (idEx)
    );

    executeStage execute (
        .CLK     (CLK),
        .rst     (rst),
        .idEx    (idEx),
        .fwd     (fwd),
        .wb      (wb),
        .exMem   (exMem),
        .redirect(redirect)
    );

    memoryStage memory (
        .CLK      (CLK),
        .rst      (rst),
        .exMem    (exMem),
        .readData (readData),
        .memAddr  (memAddr),
        .writeData(writeData),
        .memWrite (memWrite),
        .memRead  (memRead),
        .wb       (wb)
    );

    hazardUnit hazard (
        .ifId         (ifId),
        .idEx         (idEx),
        .exMem        (exMem),
        .wb           (wb),
        .redirectTaken(redirect.taken),
        .stall        (stall),
        .flushD       (flushD),
        .flushE       (flushE),
        .fwd          (fwd)
    );

endmodule

`default_nettype wire

//--- source/rvIsaPkg.sv
`default_nettype none

`include "rv_config.svh"

package rvIsaPkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_XLEN-1:0] addr_t;
    typedef logic [31:0]         instr_t;
    typedef logic [4:0]          regIdx_t;
    typedef logic [6:0]          opcode_t;
    typedef logic [2:0]          funct3_t;
    typedef logic [3:0]          aluOp_t;

    // Major opcodes
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    localparam instr_t NOP_INSTR = 32'h00000013;   // addi x0, x0, 0

    // ALU funct3, shared by OP and OP-IMM
    localparam funct3_t F3_ADD = 3'b000;
    localparam funct3_t F3_SLL = 3'b001;
    localparam funct3_t F3_SLT = 3'b010;
    localparam funct3_t F3_XOR = 3'b100;
    localparam funct3_t F3_SR  = 3'b101;   // SRL or SRA by bit 30
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;

    // Branch conditions
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;
    localparam funct3_t F3_BLT = 3'b100;
    localparam funct3_t F3_BGE = 3'b101;

    // ALU operations
    localparam aluOp_t ALU_ADD = 4'd0;
    localparam aluOp_t ALU_SUB = 4'd1;
    localparam aluOp_t ALU_AND = 4'd2;
    localparam aluOp_t ALU_OR  = 4'd3;
    localparam aluOp_t ALU_XOR = 4'd4;
    localparam aluOp_t ALU_SLT = 4'd5;
    localparam aluOp_t ALU_SLL = 4'd6;
    localparam aluOp_t ALU_SRL = 4'd7;
    localparam aluOp_t ALU_SRA = 4'd8;

endpackage

`default_nettype wire

//--- source/rvPipePkg.sv
`default_nettype none

package rvPipePkg;
    import rvIsaPkg::*;

    // Decoded control bundle
    typedef struct packed {
        logic   regWrite;
        logic   memToReg;   // Writeback takes load data
        logic   memWrite;
        logic   isBranch;
        aluOp_t aluOp;
        logic   srcAZero;   // LUI adds to zero
        logic   srcBImm;
    } ctrl_t;

    typedef struct packed {
        instr_t instr;
        addr_t  pc;
    } ifId_t;

    typedef struct packed {
        ctrl_t   ctrl;
        addr_t   pc;
        word_t   rs1Val;
        word_t   rs2Val;
        word_t   imm;
        regIdx_t rs1;
        regIdx_t rs2;
        regIdx_t rd;
        funct3_t funct3;   // Branch condition
    } idEx_t;

    typedef struct packed {
        logic    regWrite;
        logic    memToReg;
        logic    memWrite;
        word_t   aluResult;   // Also the data memory address
        word_t   storeData;
        regIdx_t rd;
    } exMem_t;

    typedef struct packed {
        logic    regWrite;
        logic    memToReg;
        word_t   aluResult;
        word_t   loadData;
        regIdx_t rd;
    } memWb_t;

    // Register write, also the decode bypass and execute forward source
    typedef struct packed {
        logic    regWrite;
        regIdx_t rd;
        word_t   result;
    } wbPort_t;

    typedef struct packed {
        logic  taken;
        addr_t target;
    } redirect_t;

    // ========================================
    // Forwarding selects
    // ========================================
    typedef logic [1:0] fwdSrc_t;

    localparam fwdSrc_t FWD_NONE = 2'd0;
    localparam fwdSrc_t FWD_WB   = 2'd1;
    localparam fwdSrc_t FWD_MEM  = 2'd2;

    typedef struct packed {
        fwdSrc_t fwdA;
        fwdSrc_t fwdB;
    } fwdSel_t;

endpackage

`default_nettype wire

//--- source/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Datapath and byte address width
`define RV_XLEN 32

// First fetch address after reset
`define RV_PC_INIT 32'h00400000

`define RV_REG_COUNT 32   // Integer register file entries

`endif

//--- tests/rvCoreTb.sv
`default_nettype none
`timescale 1ns/10ps

`include "rv_config.svh"

module rvCoreTb;
    import rvIsaPkg::*;

    typedef struct packed {
        addr_t addr;
        word_t data;
    } storeRec_t;

    localparam int        IMEM_WORDS = 64;
    localparam int        DMEM_WORDS = 64;
    localparam addr_t     DATA_BASE  = 32'h00000100;
    localparam funct3_t   F3_WORD    = 3'b010;
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;   // SUB and SRA

    logic   CLK;
    logic   rst;
    instr_t instr;
    word_t  readData;
    addr_t  pc;
    addr_t  memAddr;
    word_t  writeData;
    logic   memWrite;
    logic   memRead;

    instr_t    imem [IMEM_WORDS];
    word_t     dmem [DMEM_WORDS];
    instr_t    prog[$];
    storeRec_t expected[$];
    int        seed       = 92;
    int        storeIdx   = 0;
    int        cycles     = 0;
    int        cycleLimit = 1000;

    rvCore dut_i (
        .CLK      (CLK),
        .rst      (rst),
        .instr    (instr),
        .readData (readData),
        .pc       (pc),
        .memAddr  (memAddr),
        .writeData(writeData),
        .memWrite (memWrite),
        .memRead  (memRead)
    );

    always #2 CLK = ~CLK;

    // ========================================
    // Instruction encoding
    // ========================================
    function automatic instr_t rType(logic [6:0] f7, funct3_t f3, int rd, int rs1, int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_REG};
    endfunction

    function automatic instr_t iType(opcode_t op, funct3_t f3, int rd, int rs1, int imm);
        logic [11:0] imm12;
        imm12 = imm[11:0];
        return {imm12, rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic instr_t sType(int rs2, int rs1, int offset);
        logic [11:0] s;
        s = offset[11:0];
        return {s[11:5], rs2[4:0], rs1[4:0], F3_WORD, s[4:0], OP_STORE};
    endfunction

    function automatic instr_t bType(funct3_t f3, int rs1, int rs2, int offset);
        logic [12:0] b;
        b = offset[12:0];
        return {b[12], b[10:5], rs2[4:0], rs1[4:0], f3, b[4:1], b[11], OP_BRANCH};
    endfunction

    function automatic instr_t uType(int rd, logic [19:0] upper);
        return {upper, rd[4:0], OP_LUI};
    endfunction

    // ========================================
    // Memory models
    // ========================================
    function automatic instr_t fetchWord(addr_t a);
        addr_t off;
        off = a - `RV_PC_INIT;
        if (off < addr_t'(IMEM_WORDS * 4)) begin
            return imem[off[7:2]];
        end
        return NOP_INSTR;   // Past the program
    endfunction

    function automatic word_t loadWord(addr_t a);
        addr_t off;
        off = a - DATA_BASE;
        if (off < addr_t'(DMEM_WORDS * 4)) begin
            return dmem[off[7:2]];
        end
        return '0;
    endfunction

    task automatic writeWord(addr_t a, word_t d);
        addr_t off;
        off = a - DATA_BASE;
        if (off < addr_t'(DMEM_WORDS * 4)) begin
            dmem[off[7:2]] = d;
        end
    endtask

    task automatic presetData();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i[5:0]] = $random(seed);
        end
    endtask

    task automatic emit(instr_t i);
        prog.push_back(i);
    endtask

    task automatic expectStore(addr_t a, word_t d);
        expected.push_back('{addr: a, data: d});
    endtask

    // ========================================
    // Program and expected stores
    // ========================================
    task automatic buildProgram();
        // Dependent ALU chain fed from memory and writeback
        emit(iType(OP_IMM, F3_ADD, 1, 0, 100));
        emit(iType(OP_IMM, F3_ADD, 2, 1, -30));
        emit(rType(F7_ALT, F3_ADD, 3, 1, 2));                 // 100 - 70
        emit(iType(OP_IMM, F3_SLL, 4, 3, 3));
        emit(sType(4, 0, 32'h100));
        expectStore(32'h100, 32'd240);
        emit(iType(OP_IMM, F3_ADD, 5, 0, -16));
        emit(iType(OP_IMM, F3_SR, 6, 5, 32'h402));           // srai by 2
        emit(iType(OP_IMM, F3_SR, 7, 5, 28));                 // srli by 28
        emit(rType(F7_BASE, F3_SLT, 8, 6, 7));                // -4 < 15
        emit(rType(F7_BASE, F3_SLL, 9, 7, 8));
        emit(rType(F7_ALT, F3_SR, 10, 5, 8));
        emit(rType(F7_BASE, F3_SR, 11, 5, 7));
        emit(rType(F7_BASE, F3_XOR, 12, 10, 9));
        emit(sType(8, 0, 32'h104));
        expectStore(32'h104, 32'd1);
        emit(sType(11, 0, 32'h108));
        expectStore(32'h108, 32'h0001FFFF);                   // 0xFFFFFFF0 >> 15
        emit(sType(12, 0, 32'h10C));
        expectStore(32'h10C, 32'hFFFFFFE6);
        emit(iType(OP_IMM, F3_SLT, 13, 5, -20));              // -16 < -20 is false
        emit(iType(OP_IMM, F3_OR, 14, 13, 32'h55));
        emit(iType(OP_IMM, F3_AND, 15, 12, 32'hF0));
        emit(iType(OP_IMM, F3_XOR, 16, 15, -1));
        emit(rType(F7_BASE, F3_AND, 17, 16, 14));
        emit(rType(F7_BASE, F3_OR, 18, 17, 15));
        emit(rType(F7_BASE, F3_ADD, 19, 18, 16));             // 0xF5 + 0xFFFFFF1F
        emit(sType(19, 0, 32'h110));
        expectStore(32'h110, 32'h00000014);

        // Load-use pairs
        emit(iType(OP_LOAD, F3_WORD, 20, 0, 32'h180));
        emit(iType(OP_IMM, F3_ADD, 21, 20, 7));
        emit(sType(21, 0, 32'h114));
        expectStore(32'h114, loadWord(32'h180) + 32'd7);
        emit(iType(OP_LOAD, F3_WORD, 22, 0, 32'h184));
        emit(sType(22, 0, 32'h118));                           // Store data from the load
        expectStore(32'h118, loadWord(32'h184));

        // ========================================
        // Branches
        // ========================================
        emit(iType(OP_IMM, F3_ADD, 23, 0, 5));
        emit(iType(OP_IMM, F3_ADD, 24, 0, -3));
        emit(bType(F3_BEQ, 23, 23, 12));                      // Taken
        emit(sType(23, 0, 32'h11C));                          // Wrong path
        emit(sType(24, 0, 32'h11C));                          // Wrong path
        emit(bType(F3_BNE, 23, 23, 8));                       // Not taken
        emit(sType(23, 0, 32'h11C));
        expectStore(32'h11C, 32'd5);
        emit(bType(F3_BLT, 24, 23, 12));                      // Taken as -3 < 5
        emit(sType(24, 0, 32'h120));                          // Wrong path
        emit(iType(OP_IMM, F3_ADD, 23, 0, 99));               // Squashed write
        emit(bType(F3_BGE, 24, 23, 8));                       // Not taken
        emit(sType(23, 0, 32'h120));
        expectStore(32'h120, 32'd5);

        // Decode bypass three slots later and the x0 write
        emit(iType(OP_IMM, F3_ADD, 25, 0, 32'h123));
        emit(iType(OP_IMM, F3_ADD, 26, 0, 1));
        emit(iType(OP_IMM, F3_ADD, 27, 0, 2));
        emit(sType(25, 0, 32'h124));
        expectStore(32'h124, 32'h00000123);
        emit(iType(OP_IMM, F3_ADD, 0, 0, 77));
        emit(sType(0, 0, 32'h128));
        expectStore(32'h128, 32'h00000000);

        // Full constant from LUI and ADDI
        emit(uType(28, 20'hDEADC));
        emit(iType(OP_IMM, F3_ADD, 28, 28, -32'h111));
        emit(sType(28, 0, 32'h12C));
        expectStore(32'h12C, 32'hDEADBEEF);
    endtask

    // ========================================
    // Checks
    // ========================================
    task automatic stopRun();
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first failed check");
    endtask

    task automatic checkAddr(addr_t actual, addr_t exp, string what);
        if (actual !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, exp);
            stopRun();
        end
    endtask

    task automatic checkWord(word_t actual, word_t exp, string what);
        if (actual !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, exp);
            stopRun();
        end
    endtask

    task automatic checkStore();
        checkAddr(memAddr, expected[storeIdx].addr, "store address");
        checkWord(writeData, expected[storeIdx].data, "store data");
        writeWord(memAddr, writeData);
        storeIdx++;
    endtask

    // Memory responses and store checks on the falling edge
    always @(negedge CLK) begin
        if (memWrite) begin
            checkStore();
        end
        if (expected.size() > 0 && storeIdx == expected.size()) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            instr    = fetchWord(pc);
            readData = memRead ? loadWord(memAddr) : '0;   // Data only on a read
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Timeout: %0d of %0d stores seen after %0d cycles",
                     storeIdx, expected.size(), cycles);
            stopRun();
        end
    end

    initial begin
        CLK      = 1'b0;
        rst      = 1'b1;
        instr    = NOP_INSTR;
        readData = '0;
        presetData();
        buildProgram();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i[5:0]] = NOP_INSTR;
        end
        for (int i = 0; i < prog.size(); i++) begin
            imem[i[5:0]] = prog[i];
        end
        cycleLimit = prog.size() * 3 + 20;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;
        checkAddr(pc, `RV_PC_INIT, "pc after reset");
    end

endmodule

`default_nettype wire

//--- tests/rvCore_assert.sv
`default_nettype none
`timescale 1ns/10ps

module rvCoreAssert (
    input logic            CLK,
    input logic            rst,
    input rvIsaPkg::addr_t pc,
    input logic            memWrite,
    input logic            memRead
);

    // One data port, so a load and a store never share a cycle
    memExclusive: assert property (@(posedge CLK) disable iff (rst) !(memWrite && memRead))
        else $error("memWrite and memRead are high in the same cycle");

    pcAligned: assert property (@(posedge CLK) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

    // Stage registers leave reset holding bubbles
    quietAfterReset: assert property (@(posedge CLK) rst |=> (!memWrite && !memRead))
        else $error("data memory access in the cycle after reset");

endmodule

bind rvCore rvCoreAssert checks (
    .CLK     (CLK),
    .rst     (rst),
    .pc      (pc),
    .memWrite(memWrite),
    .memRead (memRead)
);

`default_nettype wire
